// File: int_vector_caster.f
hdl/int_cast_pkg.sv
hdl/pipe_stage.sv
hdl/cast_config_regs.sv
hdl/lane_extend.sv
hdl/lane_pack.sv
hdl/int_vector_caster.sv
bench/tb_clock_gen.sv
bench/tb_int_vector_caster.sv

// File: Bender.yml
package:
  name: int_vector_caster

sources:
  - hdl/int_cast_pkg.sv
  - hdl/pipe_stage.sv
  - hdl/cast_config_regs.sv
  - hdl/lane_extend.sv
  - hdl/lane_pack.sv
  - hdl/int_vector_caster.sv
  - target: simulation
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_int_vector_caster.sv

// File: bench/tb_int_vector_caster.sv
`timescale 1ns/100ps

module tb_int_vector_caster;

	import int_cast_pkg::*;

	localparam int TIMEOUT_CYCLES = 200;

	logic clk;
	logic arst_n;
	logic cfg_valid;
	logic cfg_ready;
	cast_cfg_t cfg_data;
	logic in_valid;
	logic in_ready;
	vec_t in_data;
	logic out_valid;
	logic out_ready;
	vec_t out_data;

	logic [31:0] lfsr_state;
	cast_cfg_t model_cfg;
	vec_t expected_q[$];
	logic last_in_acc;
	logic last_cfg_acc;
	logic hold_pending;
	vec_t held_data;
	int value_errors;
	int handshake_errors;
	int other_errors;

	tb_clock_gen u_tb_clock_gen
	(
		.clk    (clk),
		.arst_n (arst_n)
	);

	int_vector_caster u_int_vector_caster
	(
		.clk       (clk),
		.arst_n    (arst_n),
		.cfg_valid (cfg_valid),
		.cfg_ready (cfg_ready),
		.cfg_data  (cfg_data),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

	// Taps for x^32 + x^22 + x^2 + x + 1.
	function automatic logic next_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic vec_t rand_vec();
		vec_t v;
		for (int i = 0; i < VEC_BITS; i++)
		begin
			v[i] = next_bit();
		end
		return v;
	endfunction

	function automatic cast_cfg_t rand_cfg();
		cast_cfg_t c;
		c.src_size = int_size_e'({next_bit(), next_bit()});
		c.dst_size = int_size_e'({next_bit(), next_bit()});
		c.src_signed = next_bit();
		return c;
	endfunction

	// Element i keeps its index; the wider size sets how many elements exist.
	function automatic vec_t model_cast(input vec_t src, input cast_cfg_t cfg);
		int sb;
		int db;
		int n;
		logic [63:0] smask;
		logic [63:0] dmask;
		logic [63:0] e;
		vec_t res;
		sb = 8 << int'(cfg.src_size);
		db = 8 << int'(cfg.dst_size);
		n = (sb > db) ? 256 / sb : 256 / db;
		smask = (sb == 64) ? '1 : ((64'd1 << sb) - 64'd1);
		dmask = (db == 64) ? '1 : ((64'd1 << db) - 64'd1);
		res = '0;
		for (int i = 0; i < n; i++)
		begin
			e = 64'(src >> (i * sb)) & smask;
			if (cfg.src_signed && e[sb-1])
				e = e | ~smask;
			res = res | (vec_t'(e & dmask) << (i * db));
		end
		return res;
	endfunction

	task automatic check_vec(input string name, input vec_t got, input vec_t exp);
		if (got !== exp)
		begin
			$display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_cfg_handshake(input string name, input cast_cfg_t cfg,
		input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("[ERROR] %0t %s (cfg %s to %s, signed %b): got %b expected %b",
				$time, name, cfg.src_size.name(), cfg.dst_size.name(), cfg.src_signed,
				got, exp);
			handshake_errors++;
		end
	endtask

	task automatic finish_run();
		$display("errors: value %0d, handshake %0d, other %0d",
			value_errors, handshake_errors, other_errors);
		if (value_errors + handshake_errors + other_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out after %0d cycles waiting for %s.", TIMEOUT_CYCLES, what);
		other_errors++;
		finish_run();
	endtask

	// Inputs change on the falling edge; handshakes are read once they settle.
	task automatic run_cycle(input logic iv, input vec_t id, input logic cv,
		input cast_cfg_t cd, input logic ordy);
		logic in_acc;
		logic cfg_acc;
		logic out_acc;
		vec_t exp;
		@(negedge clk);
		in_valid = iv;
		in_data = id;
		cfg_valid = cv;
		cfg_data = cd;
		out_ready = ordy;
		#1;
		// A word refused on the last edge must still be offered unchanged.
		if (hold_pending)
		begin
			check_cfg_handshake("out_valid while stalled", model_cfg, out_valid, 1'b1);
			check_vec("out_data while stalled", out_data, held_data);
		end
		in_acc = in_valid && in_ready;
		cfg_acc = cfg_valid && cfg_ready;
		out_acc = out_valid && out_ready;
		if (!cfg_ready)
			check_cfg_handshake("in_ready while pending", model_cfg, in_ready, 1'b0);
		if (out_acc)
		begin
			if (expected_q.size() == 0)
			begin
				$display("Output word %h arrived with none expected at %0t.", out_data, $time);
				other_errors++;
			end
			else
			begin
				exp = expected_q.pop_front();
				check_vec("out_data", out_data, exp);
			end
		end
		// A word taken on the same edge as a configuration still uses the old one.
		if (in_acc)
			expected_q.push_back(model_cast(in_data, model_cfg));
		if (cfg_acc)
			model_cfg = cfg_data;
		hold_pending = out_valid && !out_ready;
		held_data = out_data;
		last_in_acc = in_acc;
		last_cfg_acc = cfg_acc;
	endtask

	task automatic send_word(input vec_t w, input logic ordy);
		int n;
		n = 0;
		last_in_acc = 1'b0;
		while (!last_in_acc && n < TIMEOUT_CYCLES)
		begin
			run_cycle(1'b1, w, 1'b0, cfg_data, ordy);
			n++;
		end
		if (!last_in_acc)
			report_timeout("in_ready");
	endtask

	task automatic write_cfg(input cast_cfg_t c);
		int n;
		n = 0;
		last_cfg_acc = 1'b0;
		while (!last_cfg_acc && n < TIMEOUT_CYCLES)
		begin
			run_cycle(1'b0, in_data, 1'b1, c, 1'b1);
			n++;
		end
		if (!last_cfg_acc)
			report_timeout("cfg_ready");
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (expected_q.size() > 0 && n < TIMEOUT_CYCLES)
		begin
			run_cycle(1'b0, in_data, 1'b0, cfg_data, 1'b1);
			n++;
		end
		if (expected_q.size() > 0)
			report_timeout("the pipeline to drain");
	endtask

	task automatic run_random(input int cycles);
		logic offering;
		vec_t word;
		offering = 1'b0;
		word = '0;
		for (int i = 0; i < cycles; i++)
		begin
			if (!offering)
			begin
				offering = next_bit();
				word = rand_vec();
			end
			run_cycle(offering, word, 1'b0, cfg_data, next_bit());
			if (last_in_acc)
				offering = 1'b0;
		end
		drain();
	endtask

	initial
	begin
		int n;
		cast_cfg_t c;
		cast_cfg_t cfg_b;
		lfsr_state = 32'h54fb;
		cfg_valid = 1'b0;
		cfg_data = '0;
		in_valid = 1'b0;
		in_data = '0;
		out_ready = 1'b0;
		model_cfg = '{src_size: SZ8, dst_size: SZ8, src_signed: 1'b0};
		hold_pending = 1'b0;
		held_data = '0;
		value_errors = 0;
		handshake_errors = 0;
		other_errors = 0;

		n = 0;
		while (arst_n !== 1'b1 && n < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			n++;
		end
		if (arst_n !== 1'b1)
			report_timeout("reset release");

		@(negedge clk);
		check_cfg_handshake("out_valid after reset", model_cfg, out_valid, 1'b0);
		check_cfg_handshake("cfg_ready after reset", model_cfg, cfg_ready, 1'b1);
		check_cfg_handshake("in_ready after reset", model_cfg, in_ready, 1'b1);
		for (int i = 0; i < 4; i++)
			send_word(rand_vec(), 1'b1);
		drain();

		// Every size pair, both signedness settings, with top bits set and clear.
		for (int s = 0; s < 4; s++)
		begin
			for (int d = 0; d < 4; d++)
			begin
				for (int sg = 0; sg < 2; sg++)
				begin
					c.src_size = int_size_e'(s);
					c.dst_size = int_size_e'(d);
					c.src_signed = sg[0];
					write_cfg(c);
					send_word('1, 1'b1);
					send_word({32{8'h80}}, 1'b1);
					send_word({32{8'h7f}}, 1'b1);
					send_word(rand_vec(), 1'b1);
					drain();
				end
			end
		end

		for (int k = 0; k < 4; k++)
		begin
			write_cfg(rand_cfg());
			run_random(150);
		end

		// Fill both stages, then write a new configuration behind them.
		write_cfg('{src_size: SZ8, dst_size: SZ32, src_signed: 1'b1});
		drain();
		send_word(rand_vec(), 1'b0);
		send_word(rand_vec(), 1'b0);
		cfg_b = '{src_size: SZ64, dst_size: SZ16, src_signed: 1'b0};
		run_cycle(1'b1, rand_vec(), 1'b1, cfg_b, 1'b0);
		check_cfg_handshake("cfg accepted with stages full", cfg_b, last_cfg_acc, 1'b1);
		check_cfg_handshake("word accepted with stages full", cfg_b, last_in_acc, 1'b0);
		for (int i = 0; i < 3; i++)
		begin
			run_cycle(1'b1, in_data, 1'b0, cfg_b, 1'b0);
			check_cfg_handshake("cfg_ready while stalled", cfg_b, cfg_ready, 1'b0);
			check_cfg_handshake("in_ready while stalled", cfg_b, in_ready, 1'b0);
		end
		send_word(in_data, 1'b1);
		send_word(rand_vec(), 1'b1);
		drain();

		finish_run();
	end

endmodule

// File: bench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen
(
	output logic clk,
	output logic arst_n
);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#10 clk = ~clk;
		end
	end

	// Reset covers two rising edges and is released on a falling edge.
	initial
	begin
		arst_n = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule

// File: hdl/int_vector_caster.sv
`timescale 1ns/100ps

module int_vector_caster
(
	input  logic                    clk,
	input  logic                    arst_n,

	input  logic                    cfg_valid,
	output logic                    cfg_ready,
	input  int_cast_pkg::cast_cfg_t cfg_data,

	input  logic                    in_valid,
	output logic                    in_ready,
	input  int_cast_pkg::vec_t      in_data,

	output logic                    out_valid,
	input  logic                    out_ready,
	output int_cast_pkg::vec_t      out_data
);

	import int_cast_pkg::*;

	cast_cfg_t active_cfg;

	logic s1_in_valid;
	logic s1_in_ready;
	logic s1_valid;
	logic s2_in_ready;

	elem_vec_t ext_elems;
	elem_vec_t s1_elems;
	vec_t packed_vec;

	cast_config_regs u_cast_config_regs
	(
		.clk         (clk),
		.arst_n      (arst_n),
		.cfg_valid   (cfg_valid),
		.cfg_data    (cfg_data),
		.cfg_ready   (cfg_ready),
		.in_valid    (in_valid),
		.s1_in_ready (s1_in_ready),
		.s1_valid    (s1_valid),
		.s2_valid    (out_valid),
		.in_ready    (in_ready),
		.s1_in_valid (s1_in_valid),
		.active_cfg  (active_cfg)
	);

	lane_extend u_lane_extend
	(
		.in_data    (in_data),
		.active_cfg (active_cfg),
		.elems      (ext_elems)
	);

	// First register holds the extended elements of one word.
	pipe_stage #(
		.payload_t (elem_vec_t)
	) u_s1 (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (s1_in_valid),
		.in_data   (ext_elems),
		.in_ready  (s1_in_ready),
		.out_valid (s1_valid),
		.out_data  (s1_elems),
		.out_ready (s2_in_ready)
	);

	lane_pack u_lane_pack
	(
		.elems      (s1_elems),
		.active_cfg (active_cfg),
		.out_data   (packed_vec)
	);

	pipe_stage #(
		.payload_t (vec_t)
	) u_s2 (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (s1_valid),
		.in_data   (packed_vec),
		.in_ready  (s2_in_ready),
		.out_valid (out_valid),
		.out_data  (out_data),
		.out_ready (out_ready)
	);

endmodule

// File: hdl/lane_pack.sv
`timescale 1ns/100ps

module lane_pack
(
	input  int_cast_pkg::elem_vec_t elems,
	input  int_cast_pkg::cast_cfg_t active_cfg,
	output int_cast_pkg::vec_t      out_data
);

	import int_cast_pkg::*;

	int unsigned limit;

	// A widening cast runs out of destination room before the source runs
	// out of elements, a narrowing cast the other way round.
	assign limit = produced_elems(active_cfg);

	always_comb
	begin
		out_data = '0;
		unique case (active_cfg.dst_size)
		SZ8:
		begin
			for (int i = 0; i < VEC_BITS / 8; i++)
			begin
				if (i < limit)
					out_data[i*8 +: 8] = elems[i][7:0];
			end
		end
		SZ16:
		begin
			for (int i = 0; i < VEC_BITS / 16; i++)
			begin
				if (i < limit)
					out_data[i*16 +: 16] = elems[i][15:0];
			end
		end
		SZ32:
		begin
			for (int i = 0; i < VEC_BITS / 32; i++)
			begin
				if (i < limit)
					out_data[i*32 +: 32] = elems[i][31:0];
			end
		end
		SZ64:
		begin
			for (int i = 0; i < VEC_BITS / 64; i++)
			begin
				if (i < limit)
					out_data[i*64 +: 64] = elems[i];
			end
		end
		endcase
	end

endmodule

// File: hdl/lane_extend.sv
`timescale 1ns/100ps

module lane_extend
(
	input  int_cast_pkg::vec_t      in_data,
	input  int_cast_pkg::cast_cfg_t active_cfg,
	output int_cast_pkg::elem_vec_t elems
);

	import int_cast_pkg::*;

	logic src_signed;

	assign src_signed = active_cfg.src_signed;

	// The element arrives zero-extended; a signed element with its top bit
	// set gets ones above its own width.
	function automatic logic [ELEM_BITS-1:0] extend_elem(
		input logic [ELEM_BITS-1:0] raw,
		input int_size_e size,
		input logic sgn
	);
		logic [ELEM_BITS-1:0] keep;
		logic msb;
		keep = size_mask(size);
		msb = raw[size_bits(size) - 1];
		if (sgn && msb)
			return raw | ~keep;
		return raw & keep;
	endfunction

	// Slots past the source element count stay zero.
	always_comb
	begin
		elems = '0;
		unique case (active_cfg.src_size)
		SZ8:
		begin
			for (int i = 0; i < VEC_BITS / 8; i++)
			begin
				elems[i] = extend_elem(ELEM_BITS'(in_data[i*8 +: 8]), SZ8, src_signed);
			end
		end
		SZ16:
		begin
			for (int i = 0; i < VEC_BITS / 16; i++)
			begin
				elems[i] = extend_elem(ELEM_BITS'(in_data[i*16 +: 16]), SZ16,
					src_signed);
			end
		end
		SZ32:
		begin
			for (int i = 0; i < VEC_BITS / 32; i++)
			begin
				elems[i] = extend_elem(ELEM_BITS'(in_data[i*32 +: 32]), SZ32,
					src_signed);
			end
		end
		SZ64:
		begin
			for (int i = 0; i < VEC_BITS / 64; i++)
			begin
				elems[i] = in_data[i*64 +: 64];
			end
		end
		endcase
	end

endmodule

// File: hdl/cast_config_regs.sv
`timescale 1ns/100ps

module cast_config_regs
(
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    cfg_valid,
	input  int_cast_pkg::cast_cfg_t cfg_data,
	output logic                    cfg_ready,
	input  logic                    in_valid,
	input  logic                    s1_in_ready,
	input  logic                    s1_valid,
	input  logic                    s2_valid,
	output logic                    in_ready,
	output logic                    s1_in_valid,
	output int_cast_pkg::cast_cfg_t active_cfg
);

	import int_cast_pkg::*;

	logic pending_valid;
	cast_cfg_t pending_cfg;
	logic cfg_accept;
	logic pipe_empty;
	logic commit;

	assign cfg_ready = !pending_valid;
	assign cfg_accept = cfg_valid && cfg_ready;

	// Both stage valids low means no word is left that was cast under the
	// old setting.
	assign pipe_empty = !s1_valid && !s2_valid;
	assign commit = pending_valid && pipe_empty;

	// New words wait behind a pending configuration, so it can never
	// overtake words that were already admitted.
	assign in_ready = !pending_valid && s1_in_ready;
	assign s1_in_valid = in_valid && !pending_valid;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pending_valid <= 1'b0;
			active_cfg <= CFG_RESET;
		end
		else
		begin
			if (cfg_accept)
			begin
				pending_valid <= 1'b1;
			end
			else if (commit)
			begin
				pending_valid <= 1'b0;
				active_cfg <= pending_cfg;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (cfg_accept)
		begin
			pending_cfg <= cfg_data;
		end
	end

	// Both datapath halves read active_cfg, so it has to stay put until the
	// last word in flight has left the second stage.
	property p_cfg_stable_in_flight;
		@(posedge clk) disable iff (!arst_n)
		(s1_valid || s2_valid) |=> $stable(active_cfg);
	endproperty

	a_cfg_stable_in_flight: assert property (p_cfg_stable_in_flight)
		else $error("active configuration changed with words in flight");

endmodule

// File: hdl/pipe_stage.sv
`timescale 1ns/100ps

module pipe_stage #(
	parameter type payload_t = logic
)
(
	input  logic     clk,
	input  logic     arst_n,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     in_ready,
	output logic     out_valid,
	output payload_t out_data,
	input  logic     out_ready
);

	logic load;

	// The register takes a new word in the same cycle its old word leaves,
	// so a full stage still moves one word per clock.
	assign in_ready = !out_valid || out_ready;
	assign load = in_valid && in_ready;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			out_valid <= 1'b0;
		end
		else if (in_ready)
		begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			out_data <= in_data;
		end
	end

	// A stalled word must sit still until the consumer takes it.
	property p_hold_on_stall;
		@(posedge clk) disable iff (!arst_n)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_data));
	endproperty

	a_hold_on_stall: assert property (p_hold_on_stall)
		else $error("pipe_stage output changed while stalled");

endmodule

// File: hdl/int_cast_pkg.sv
package int_cast_pkg;

	localparam int VEC_BITS = 256;
	localparam int ELEM_BITS = 64;

	// The 8-bit case packs the most elements into one word.
	localparam int MAX_ELEMS = VEC_BITS / 8;

	typedef enum logic [1:0]
	{
		SZ8 = 2'd0,
		SZ16 = 2'd1,
		SZ32 = 2'd2,
		SZ64 = 2'd3
	} int_size_e;

	typedef struct packed
	{
		int_size_e src_size;
		int_size_e dst_size;
		logic src_signed;
	} cast_cfg_t;

	typedef logic [VEC_BITS-1:0] vec_t;
	typedef logic [MAX_ELEMS-1:0][ELEM_BITS-1:0] elem_vec_t;

	localparam cast_cfg_t CFG_RESET = '{src_size: SZ8, dst_size: SZ8, src_signed: 1'b0};

	function automatic int unsigned size_bits(input int_size_e size);
		return 32'd8 << size;
	endfunction

	function automatic int unsigned elem_count(input int_size_e size);
		return VEC_BITS / size_bits(size);
	endfunction

	// Ones in the low bits that an element of this size occupies.
	function automatic logic [ELEM_BITS-1:0] size_mask(input int_size_e size);
		logic [ELEM_BITS-1:0] ones;
		ones = '1;
		return ones >> (ELEM_BITS - size_bits(size));
	endfunction

	// The wider of the two sizes decides how many elements a cast yields.
	function automatic int unsigned produced_elems(input cast_cfg_t cfg);
		int unsigned src_n;
		int unsigned dst_n;
		src_n = elem_count(cfg.src_size);
		dst_n = elem_count(cfg.dst_size);
		return (src_n < dst_n) ? src_n : dst_n;
	endfunction

endpackage
